// File: hdl/a2_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Apple II bus timing, card response and bus drive definitions.
// Card slots are in priority order, so the lowest index wins the data bus.
// All strobes are single cycles of the logic clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package a2_bus_pkg;

    localparam int NUM_CARDS = 4;

    // Slot order = read priority
    localparam int CARD_SERIAL  = 0;
    localparam int CARD_SPRITE  = 1;
    localparam int CARD_MOCKING = 2;
    localparam int CARD_DISK    = 3;

    // Allow driving the Apple bus
    localparam bit BUS_DATA_OUT_ENABLE = 1'b1;
    localparam bit IRQ_OUT_ENABLE      = 1'b1;

    // Bus clocks seen in the logic clock domain
    typedef struct packed {
        logic phi0;
        logic phi1;
        logic phi1_rise;
        logic phi1_fall;
        logic clk_2m_edge;     // Either phi1 edge
        logic clk_7m;
        logic clk_7m_rise;
        logic clk_7m_fall;
        logic clk_14m_edge;    // Either 7M edge
    } a2_timing_t;

    typedef struct packed {
        logic [7:0] data;
        logic       rd_en;     // Card wants the data bus
        logic       irq_n;
    } card_resp_t;

    typedef struct packed {
        logic [7:0] data_out;
        logic       data_out_en;
        logic       irq_n;
    } bus_drive_t;

endpackage

// File: hdl/a2_av_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Audio sample and pixel colour definitions.
// Samples are unsigned 16 bit and the mix wraps, it does not saturate.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package a2_av_pkg;

    localparam int SAMPLE_W   = 16;
    localparam int MB_AUDIO_W = 10;

    // Mix scaling, as left shifts
    localparam int MB_SHIFT      = 5;
    localparam int SPEAKER_SHIFT = 13;

    localparam int COLOR_W = 8;

    // Build time forces, the DIP switches can still turn these on
    localparam bit SCANLINES_ENABLE     = 1'b0;
    localparam bit APPLE_SPEAKER_ENABLE = 1'b0;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } stereo_t;

endpackage

// File: hdl/a2_clock_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Brings phi1 and 7M into the logic clock and derives the edge strobes.
// Levels lag their pins by 2 logic clocks, so the logic clock must be
// well above 14 MHz. The Apple reset is merged and released in sync.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_clock_sync (
    input  logic                   clk_logic_w,
    input  logic                   arst_n_i,
    input  logic                   a2_phi1_i,
    input  logic                   a2_7m_i,
    input  logic                   a2_reset_n_i,
    output a2_bus_pkg::a2_timing_t timing_o,
    output logic                   system_rst_n_o
);

    logic       rst_comb_n;
    logic [1:0] rst_sync_q;
    logic [2:0] phi1_q;        // [1:0] sync, [2] edge history
    logic [2:0] clk_7m_q;
    logic       phi0_q;

    // Either reset source asserts at once
    assign rst_comb_n = arst_n_i & a2_reset_n_i;

    always_ff @(posedge clk_logic_w or negedge rst_comb_n) begin
        if (!rst_comb_n) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign system_rst_n_o = rst_sync_q[1];

    always_ff @(posedge clk_logic_w or negedge system_rst_n_o) begin
        if (!system_rst_n_o) begin
            phi1_q   <= 3'b000;
            clk_7m_q <= 3'b000;
            phi0_q   <= 1'b0;
        end else begin
            phi1_q   <= {phi1_q[1:0], a2_phi1_i};
            clk_7m_q <= {clk_7m_q[1:0], a2_7m_i};
            // Lands together with phi1_q[1]
            phi0_q   <= ~phi1_q[0];
        end
    end

    assign timing_o.phi0         = phi0_q;
    assign timing_o.phi1         = phi1_q[1];
    assign timing_o.phi1_rise    = phi1_q[1] & ~phi1_q[2];
    assign timing_o.phi1_fall    = ~phi1_q[1] & phi1_q[2];
    assign timing_o.clk_2m_edge  = phi1_q[1] ^ phi1_q[2];      // Rise or fall
    assign timing_o.clk_7m       = clk_7m_q[1];
    assign timing_o.clk_7m_rise  = clk_7m_q[1] & ~clk_7m_q[2];
    assign timing_o.clk_7m_fall  = ~clk_7m_q[1] & clk_7m_q[2];
    assign timing_o.clk_14m_edge = clk_7m_q[1] ^ clk_7m_q[2];

endmodule

// File: hdl/a2_card_response.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chooses which card drives read data and merges the card interrupts.
// Fixed priority by slot index, one cycle of latency.
// With no card reading, the data follows the bus and the enable is low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_card_response (
    input  logic                                                clk_logic_w,
    input  logic                                                arst_n_i,
    input  a2_bus_pkg::card_resp_t [a2_bus_pkg::NUM_CARDS-1:0] card_i,
    input  logic [7:0]                                          bus_data_i,
    output a2_bus_pkg::bus_drive_t                              drive_o
);

    logic [7:0] sel_data;
    logic       any_rd;
    logic       all_irq_n;
    logic [7:0] data_q;
    logic       data_en_q;
    logic       irq_n_q;

    always_comb begin
        any_rd    = 1'b0;
        all_irq_n = 1'b1;
        for (int i = 0; i < a2_bus_pkg::NUM_CARDS; i++) begin
            any_rd    = any_rd | card_i[i].rd_en;
            all_irq_n = all_irq_n & card_i[i].irq_n;     // Wired-AND of open drains
        end
    end

    // Serial card first, disk last
    assign sel_data =
        card_i[a2_bus_pkg::CARD_SERIAL].rd_en  ? card_i[a2_bus_pkg::CARD_SERIAL].data  :
        card_i[a2_bus_pkg::CARD_SPRITE].rd_en  ? card_i[a2_bus_pkg::CARD_SPRITE].data  :
        card_i[a2_bus_pkg::CARD_MOCKING].rd_en ? card_i[a2_bus_pkg::CARD_MOCKING].data :
        card_i[a2_bus_pkg::CARD_DISK].rd_en    ? card_i[a2_bus_pkg::CARD_DISK].data    :
        bus_data_i;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_en_q <= 1'b0;
            irq_n_q   <= 1'b1;
        end else begin
            data_en_q <= any_rd & a2_bus_pkg::BUS_DATA_OUT_ENABLE;
            irq_n_q   <= all_irq_n | ~a2_bus_pkg::IRQ_OUT_ENABLE;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_q <= sel_data;
    end

    assign drive_o.data_out    = data_q;
    assign drive_o.data_out_en = data_en_q;
    assign drive_o.irq_n       = irq_n_q;

endmodule

// File: hdl/a2_audio_mix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sums sprite card, Mockingboard and speaker audio into stereo samples.
// The sum wraps modulo 2^16, one cycle of latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_audio_mix (
    input  logic                                clk_logic_w,
    input  logic                                arst_n_i,
    input  logic                                speaker_i,
    input  logic                                dip_speaker_n_i,
    input  logic [a2_av_pkg::SAMPLE_W-1:0]      sprite_audio_i,
    input  logic [a2_av_pkg::MB_AUDIO_W-1:0]    mb_left_i,
    input  logic [a2_av_pkg::MB_AUDIO_W-1:0]    mb_right_i,
    output a2_av_pkg::stereo_t                  audio_o
);

    // One channel of the mix
    function automatic logic [a2_av_pkg::SAMPLE_W-1:0] mix_channel(
        input logic [a2_av_pkg::SAMPLE_W-1:0]   sprite,
        input logic [a2_av_pkg::MB_AUDIO_W-1:0] mb,
        input logic                             spk
    );
        logic [a2_av_pkg::SAMPLE_W-1:0] mb_scaled;
        logic [a2_av_pkg::SAMPLE_W-1:0] spk_scaled;
        mb_scaled  = {{(a2_av_pkg::SAMPLE_W - a2_av_pkg::MB_AUDIO_W){1'b0}}, mb}
                     << a2_av_pkg::MB_SHIFT;
        spk_scaled = {{(a2_av_pkg::SAMPLE_W - 1){1'b0}}, spk} << a2_av_pkg::SPEAKER_SHIFT;
        return sprite + mb_scaled + spk_scaled;
    endfunction

    logic               spk_gated;
    a2_av_pkg::stereo_t mix;

    // Speaker on by build force or DIP switch 1
    assign spk_gated = speaker_i & (a2_av_pkg::APPLE_SPEAKER_ENABLE | ~dip_speaker_n_i);

    assign mix.left  = mix_channel(sprite_audio_i, mb_left_i, spk_gated);
    assign mix.right = mix_channel(sprite_audio_i, mb_right_i, spk_gated);

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            audio_o <= '0;
        end else begin
            audio_o <= mix;
        end
    end

endmodule

// File: hdl/a2_scanline_dim.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scanline effect, halves every colour on odd screen lines.
// Only bit 0 of the line number matters. One cycle of latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_scanline_dim (
    input  logic            clk_logic_w,
    input  logic            arst_n_i,
    input  a2_av_pkg::rgb_t rgb_i,
    input  logic [9:0]      screen_y_i,
    input  logic            dip_scanlines_n_i,
    output a2_av_pkg::rgb_t rgb_o
);

    logic            dim;
    a2_av_pkg::rgb_t rgb_dim;

    // DIP switch 0 low turns scanlines on
    assign dim = (a2_av_pkg::SCANLINES_ENABLE | ~dip_scanlines_n_i) & screen_y_i[0];

    assign rgb_dim.r = dim ? {1'b0, rgb_i.r[a2_av_pkg::COLOR_W-1:1]} : rgb_i.r;
    assign rgb_dim.g = dim ? {1'b0, rgb_i.g[a2_av_pkg::COLOR_W-1:1]} : rgb_i.g;
    assign rgb_dim.b = dim ? {1'b0, rgb_i.b[a2_av_pkg::COLOR_W-1:1]} : rgb_i.b;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rgb_o <= '0;
        end else begin
            rgb_o <= rgb_dim;
        end
    end

endmodule

// File: hdl/a2_bus_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Apple II card glue, top level.
// Cards are outside, they appear only as response inputs.
// An Apple reset clears the bus drive and the timing, not audio or video.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_bus_glue (
    input  logic                                                clk_logic_w,
    input  logic                                                arst_n_i,
    input  logic                                                a2_phi1_i,
    input  logic                                                a2_7m_i,
    input  logic                                                a2_reset_n_i,
    input  a2_bus_pkg::card_resp_t [a2_bus_pkg::NUM_CARDS-1:0] card_i,
    input  logic [7:0]                                          bus_data_i,
    input  logic                                                speaker_i,
    input  logic [a2_av_pkg::SAMPLE_W-1:0]                      sprite_audio_i,
    input  logic [a2_av_pkg::MB_AUDIO_W-1:0]                    mb_left_i,
    input  logic [a2_av_pkg::MB_AUDIO_W-1:0]                    mb_right_i,
    input  a2_av_pkg::rgb_t                                     rgb_i,
    input  logic [9:0]                                          screen_y_i,
    input  logic [3:0]                                          dip_switches_n_i,
    output a2_bus_pkg::a2_timing_t                              timing_o,
    output a2_bus_pkg::bus_drive_t                              drive_o,
    output a2_av_pkg::stereo_t                                  audio_o,
    output a2_av_pkg::rgb_t                                     rgb_o
);

    logic system_rst_n_w;      // Device reset and Apple reset, synced

    a2_clock_sync u_clock_sync (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (arst_n_i),
        .a2_phi1_i      (a2_phi1_i),
        .a2_7m_i        (a2_7m_i),
        .a2_reset_n_i   (a2_reset_n_i),
        .timing_o       (timing_o),
        .system_rst_n_o (system_rst_n_w)
    );

    a2_card_response u_card_response (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (system_rst_n_w),
        .card_i      (card_i),
        .bus_data_i  (bus_data_i),
        .drive_o     (drive_o)
    );

    a2_audio_mix u_audio_mix (
        .clk_logic_w     (clk_logic_w),
        .arst_n_i        (arst_n_i),
        .speaker_i       (speaker_i),
        .dip_speaker_n_i (dip_switches_n_i[1]),
        .sprite_audio_i  (sprite_audio_i),
        .mb_left_i       (mb_left_i),
        .mb_right_i      (mb_right_i),
        .audio_o         (audio_o)
    );

    a2_scanline_dim u_scanline_dim (
        .clk_logic_w       (clk_logic_w),
        .arst_n_i          (arst_n_i),
        .rgb_i             (rgb_i),
        .screen_y_i        (screen_y_i),
        .dip_scanlines_n_i (dip_switches_n_i[0]),
        .rgb_o             (rgb_o)
    );

endmodule

// File: bench/a2_glue_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compares the glue outputs at the falling edge where they are stable.
// Timing expectations are delayed 2 cycles, the other paths 1 cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module a2_glue_checker (
    input  logic                   clk_logic_w,
    input  logic                   arst_n_i,
    input  a2_bus_pkg::a2_timing_t timing_i,
    input  a2_bus_pkg::bus_drive_t drive_i,
    input  a2_av_pkg::stereo_t     audio_i,
    input  a2_av_pkg::rgb_t        rgb_i,
    input  logic [8:0]             exp_timing_i,
    input  logic [9:0]             exp_drive_i,
    input  logic [31:0]            exp_audio_i,
    input  logic [23:0]            exp_rgb_i,
    input  logic                   exp_valid_i,
    input  logic [7:0]             test_i,
    input  logic                   done_i,
    output int                     err_count_o,
    output int                     check_count_o
);

    int         test_err [256];
    int         cur_test = 0;
    logic       d1_valid = 1'b0;
    logic       d2_valid = 1'b0;
    logic [7:0] d1_test;
    logic [7:0] d2_test;
    logic [8:0] d1_timing;
    logic [8:0] d2_timing;
    logic [9:0] d1_drive;
    logic [31:0] d1_audio;
    logic [23:0] d1_rgb;

    initial begin
        err_count_o   = 0;
        check_count_o = 0;
        foreach (test_err[i]) test_err[i] = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act, input int t);
        check_count_o++;
        if (act !== exp) begin
            err_count_o++;
            test_err[t]++;
            $display("ERROR %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input int t);
        if (test_err[t] == 0) begin
            $display("Test %0d passed", t);
        end else begin
            $display("Test %0d failed with %0d mismatches", t, test_err[t]);
        end
    endtask

    // Reset values while the Apple reset synchronizer still holds
    initial begin
        @(posedge arst_n_i);
        @(negedge clk_logic_w);
        compare("timing_o", 32'h0, timing_i, 1);
        compare("drive_o.data_out_en", 32'h0, drive_i.data_out_en, 1);
        compare("drive_o.irq_n", 32'h1, drive_i.irq_n, 1);
        compare("audio_o", 32'h0, audio_i, 1);
        compare("rgb_o", 32'h0, rgb_i, 1);
    end

    always @(negedge clk_logic_w) begin
        if (d1_valid) begin
            compare("drive_o", d1_drive, drive_i, d1_test);
            compare("audio_o", d1_audio, audio_i, d1_test);
            compare("rgb_o", d1_rgb, rgb_i, d1_test);
        end
        if (d2_valid) begin
            compare("timing_o", d2_timing, timing_i, d2_test);
            if (d2_test != cur_test) begin
                if (cur_test != 0) report_test(cur_test);
                cur_test = d2_test;
            end
        end
        d2_valid  = d1_valid;
        d2_test   = d1_test;
        d2_timing = d1_timing;
        d1_valid  = exp_valid_i;
        d1_test   = test_i;
        d1_timing = exp_timing_i;
        d1_drive  = exp_drive_i;
        d1_audio  = exp_audio_i;
        d1_rgb    = exp_rgb_i;
    end

    always @(posedge done_i) begin
        if (cur_test != 0) report_test(cur_test);
        $display("Checks %0d, mismatches %0d", check_count_o, err_count_o);
    end

endmodule

// File: bench/tb_a2_bus_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the Apple II card glue. Replays the trace one line per
// logic clock, inputs driven 2 ns after the rising edge.
// Expected values come from the trace and are compared by the checker.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_a2_bus_glue;

    typedef struct packed {
        logic [7:0]       test;
        logic             phi1;
        logic             clk_7m;
        logic             reset_n;
        logic [3:0]       rd_en;     // Bit i belongs to card i
        logic [3:0]       irq_n;
        logic [3:0][7:0]  data;
        logic [7:0]       bus_data;
        logic             speaker;
        logic [15:0]      sprite;
        logic [9:0]       mb_left;
        logic [9:0]       mb_right;
        logic [23:0]      rgb;
        logic [9:0]       screen_y;
        logic [3:0]       dip_n;
        logic [8:0]       exp_timing;
        logic [9:0]       exp_drive;
        logic [31:0]      exp_audio;
        logic [23:0]      exp_rgb;
    } step_t;

    logic clk_logic_w;
    logic arst_n_i;
    logic a2_phi1_i;
    logic a2_7m_i;
    logic a2_reset_n_i;
    a2_bus_pkg::card_resp_t [a2_bus_pkg::NUM_CARDS-1:0] card_i;
    logic [7:0]       bus_data_i;
    logic             speaker_i;
    logic [15:0]      sprite_audio_i;
    logic [9:0]       mb_left_i;
    logic [9:0]       mb_right_i;
    a2_av_pkg::rgb_t  rgb_i;
    logic [9:0]       screen_y_i;
    logic [3:0]       dip_switches_n_i;
    a2_bus_pkg::a2_timing_t timing_o;
    a2_bus_pkg::bus_drive_t drive_o;
    a2_av_pkg::stereo_t     audio_o;
    a2_av_pkg::rgb_t        rgb_o;

    step_t cur;                      // Line now on the DUT inputs
    step_t idle;                     // Quiet bus, no card reading
    logic  exp_valid;
    logic  done;
    int    err_count;
    int    check_count;
    int    cycle_cnt;
    int    limit;
    bit    trace_ok;
    step_t steps[$];

    a2_bus_glue DUT (.*);

    a2_glue_checker u_checker (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .timing_i      (timing_o),
        .drive_i       (drive_o),
        .audio_i       (audio_o),
        .rgb_i         (rgb_o),
        .exp_timing_i  (cur.exp_timing),
        .exp_drive_i   (cur.exp_drive),
        .exp_audio_i   (cur.exp_audio),
        .exp_rgb_i     (cur.exp_rgb),
        .exp_valid_i   (exp_valid),
        .test_i        (cur.test),
        .done_i        (done),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    always #20 clk_logic_w = ~clk_logic_w;

    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt > limit) begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic apply_step(input step_t s);
        cur          = s;
        a2_phi1_i    = s.phi1;
        a2_7m_i      = s.clk_7m;
        a2_reset_n_i = s.reset_n;
        for (int i = 0; i < a2_bus_pkg::NUM_CARDS; i++) begin
            card_i[i].data  = s.data[i];
            card_i[i].rd_en = s.rd_en[i];
            card_i[i].irq_n = s.irq_n[i];
        end
        bus_data_i       = s.bus_data;
        speaker_i        = s.speaker;
        sprite_audio_i   = s.sprite;
        mb_left_i        = s.mb_left;
        mb_right_i       = s.mb_right;
        rgb_i            = s.rgb;
        screen_y_i       = s.screen_y;
        dip_switches_n_i = s.dip_n;
    endtask

    // Skips comment lines, keeps lines with all 22 columns
    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v [22];
        step_t       s;
        fd = $fopen("bench/a2_glue_trace.txt", "r");
        trace_ok = (fd != 0);
        if (trace_ok) begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                        v[20], v[21]);
                    if (cnt == 22) begin
                        s = {v[0][7:0], v[1][0], v[2][0], v[3][0], v[4][3:0], v[5][3:0],
                             v[9][7:0], v[8][7:0], v[7][7:0], v[6][7:0], v[10][7:0],
                             v[11][0], v[12][15:0], v[13][9:0], v[14][9:0], v[15][23:0],
                             v[16][9:0], v[17][3:0], v[18][8:0], v[19][9:0], v[20],
                             v[21][23:0]};
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk_logic_w = 1'b0;
        arst_n_i    = 1'b0;
        exp_valid   = 1'b0;
        done        = 1'b0;
        cycle_cnt   = 0;
        limit       = 0;
        idle         = '0;
        idle.reset_n = 1'b1;
        idle.irq_n   = 4'hf;
        idle.dip_n   = 4'hf;
        apply_step(idle);
        load_trace();
        if (!trace_ok || steps.size() == 0) begin
            $display("Trace file bench/a2_glue_trace.txt is missing or holds no steps");
            $display("Errors found");
            $finish;
        end else begin
            limit = steps.size() * 2 + 20;
            repeat (3) @(posedge clk_logic_w);
            #2 arst_n_i = 1'b1;
            foreach (steps[k]) begin
                @(posedge clk_logic_w);
                #2;
                apply_step(steps[k]);
                exp_valid = 1'b1;
            end
            @(posedge clk_logic_w);
            #2 exp_valid = 1'b0;
            repeat (3) @(posedge clk_logic_w);     // Drain the 2 cycle timing path
            done = 1'b1;
            #1;
            if (err_count == 0 && check_count > 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: bench/a2_glue_trace.txt
# test phi1 7m reset_n rd_en irq_n d0 d1 d2 d3 bus spk sprite mb_l mb_r rgb y dip_n
# then expected: timing(9b) drive{data,en,irq_n} audio{left,right} rgb
1 0 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 100 001 00000000 000000
1 0 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 100 001 00000000 000000
1 0 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 100 001 00000000 000000
2 1 1 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 0dd 001 00000000 000000
2 1 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 083 001 00000000 000000
2 0 1 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 13d 001 00000000 000000
2 0 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 103 001 00000000 000000
2 1 1 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 0dd 001 00000000 000000
2 0 0 1 0 f 00 00 00 00 00 0 0000 000 000 000000 000 f 133 001 00000000 000000
3 0 0 1 e f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 08b 00000000 000000
3 0 0 1 f f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 047 00000000 000000
3 0 0 1 c f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 0cf 00000000 000000
3 0 0 1 8 f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 113 00000000 000000
3 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 169 00000000 000000
4 0 0 1 0 b 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 168 00000000 000000
4 0 0 1 0 e 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 168 00000000 000000
4 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 000000 000 f 100 169 00000000 000000
5 0 0 1 0 f 11 22 33 44 5a 1 0100 001 002 000000 000 f 100 169 01200140 000000
5 0 0 1 0 f 11 22 33 44 5a 1 0100 001 002 000000 000 d 100 169 21202140 000000
5 0 0 1 0 f 11 22 33 44 5a 0 0100 001 002 000000 000 d 100 169 01200140 000000
5 0 0 1 0 f 11 22 33 44 5a 1 f000 3ff 080 000000 000 d 100 169 8fe02000 000000
5 0 0 1 0 f 11 22 33 44 5a 1 f000 3ff 080 000000 000 f 100 169 6fe00000 000000
6 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 80ff41 001 e 100 169 00000000 407f20
6 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 80ff41 002 e 100 169 00000000 80ff41
6 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 80ff41 003 f 100 169 00000000 80ff41
6 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 80ff41 3ff e 100 169 00000000 407f20
6 0 0 1 0 f 11 22 33 44 5a 0 0000 000 000 000000 000 e 100 169 00000000 000000

// File: a2_bus_glue.f
hdl/a2_bus_pkg.sv
hdl/a2_av_pkg.sv
hdl/a2_clock_sync.sv
hdl/a2_card_response.sv
hdl/a2_audio_mix.sv
hdl/a2_scanline_dim.sv
hdl/a2_bus_glue.sv
bench/a2_glue_checker.sv
bench/tb_a2_bus_glue.sv
